// File: store_buffer_pkg.sv
package store_buffer_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // constants
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int tag_width = 29;  // address bits 31 to 3.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core and memory ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;  // all zero on a load.
  } cpu_req_t;

  typedef struct packed {
    logic [63:0] rdata;
    logic        ready;
  } cpu_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        store;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [63:0] rdata;
    logic        ready;
  } mem_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_width-1:0] tag;
    logic [63:0]          data;
  } line_t;

  typedef enum logic [2:0] {
    op_load,
    op_store,
    op_uncached_load,
    op_uncached_store,
    op_flush_line
  } op_e;

  typedef struct packed {
    logic        valid;
    op_e         op;
    logic [31:0] addr;  // line index in bits 3 and up for a flush.
    logic [63:0] data;
    logic [7:0]  strb;
  } decoded_t;

  typedef struct packed {
    logic        valid;
    logic        store;
    logic        refill;  // load that fills a line.
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
  } mem_cmd_t;

endpackage

// File: store_buffer_lines.sv
module store_buffer_lines #(
  parameter int line_count = 16,
  localparam int index_width = $clog2(line_count)
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [index_width-1:0]  read_index,
  output store_buffer_pkg::line_t read_line,
  input  logic                    write_enable,
  input  logic [index_width-1:0]  write_index,
  input  store_buffer_pkg::line_t write_line
);

  store_buffer_pkg::line_t line_array [line_count];
  logic [line_count-1:0]   valid_bits;

  // valid bits live beside the array so reset can clear them.
  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_bits <= '0;
    end else if (write_enable) begin
      valid_bits[write_index] <= write_line.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      line_array[write_index] <= write_line;
    end
  end

  // invalid lines read back as all zero.
  always_comb begin
    if (valid_bits[read_index]) begin
      read_line = line_array[read_index];
    end else begin
      read_line = '0;
    end
  end

endmodule

// File: store_buffer_decode.sv
module store_buffer_decode #(
  parameter int line_count = 16,
  localparam int index_width = $clog2(line_count)
) (
  input  logic                       clock,
  input  logic                       reset,
  input  store_buffer_pkg::cpu_req_t cpu_req,
  input  logic                       done,
  output store_buffer_pkg::decoded_t request
);

  store_buffer_pkg::decoded_t pending;
  store_buffer_pkg::op_e      op_next;
  logic [index_width-1:0]     flush_index;
  logic                       flush;
  logic                       last_step;
  logic                       complete;
  logic                       hold;

  assign flush     = pending.op == store_buffer_pkg::op_flush_line;
  assign last_step = flush_index == index_width'(line_count - 1);
  assign complete  = done && (!flush || last_step);  // whole core request answered.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // classify
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (cpu_req.fence) begin
      op_next = store_buffer_pkg::op_flush_line;
    end else if (cpu_req.addr[31:28] == 4'h0) begin
      op_next = (|cpu_req.wstrb) ? store_buffer_pkg::op_uncached_store
                                 : store_buffer_pkg::op_uncached_load;
    end else begin
      op_next = (|cpu_req.wstrb) ? store_buffer_pkg::op_store
                                 : store_buffer_pkg::op_load;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // capture and fence walk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending.valid <= 1'b0;
      flush_index   <= '0;
      hold          <= 1'b0;
    end else begin
      hold <= complete;  // core still shows the answered request.
      if (pending.valid) begin
        if (complete) begin
          pending.valid <= 1'b0;
          flush_index   <= '0;
        end else if (done) begin
          flush_index <= flush_index + 1'b1;  // next line of the fence.
        end
      end else if (cpu_req.valid && !hold) begin
        pending.valid <= 1'b1;
        pending.op    <= op_next;
        pending.addr  <= cpu_req.addr;
        pending.data  <= cpu_req.wdata;
        pending.strb  <= cpu_req.wstrb;
      end
    end
  end

  always_comb begin
    request = pending;
    if (flush) begin
      request.addr = '0;
      request.addr[index_width+2:3] = flush_index;
    end
  end

  request_held: assert property (@(posedge clock) disable iff (!reset)
    request.valid && !done |=> request.valid)
    else $error("request dropped without done.");

endmodule

// File: store_buffer_execute.sv
module store_buffer_execute #(
  parameter int line_count = 16,
  localparam int index_width = $clog2(line_count)
) (
  input  logic                       clock,
  input  logic                       reset,
  input  store_buffer_pkg::decoded_t request,
  output logic                       done,
  output logic [index_width-1:0]     read_index,
  input  store_buffer_pkg::line_t    read_line,
  output logic                       write_enable,
  output logic [index_width-1:0]     write_index,
  output store_buffer_pkg::line_t    write_line,
  output store_buffer_pkg::mem_cmd_t mem_cmd,
  input  logic                       mem_done,
  input  logic [63:0]                fill_data,
  output logic                       finish,
  output logic [63:0]                finish_data
);

  typedef enum logic [2:0] {
    state_lookup,
    state_writeback,
    state_refill,
    state_update,
    state_finish
  } state_e;

  state_e state, state_next;

  logic [store_buffer_pkg::tag_width-1:0] tag;
  logic [index_width-1:0] index;
  logic [63:0] merged;
  logic [63:0] data_q;
  logic        cached, store, flush, hit, victim_dirty;

  assign index        = request.addr[index_width+2:3];
  assign tag          = request.addr[31:32-store_buffer_pkg::tag_width];
  assign read_index   = index;
  assign write_index  = index;
  assign store        = request.op == store_buffer_pkg::op_store;
  assign flush        = request.op == store_buffer_pkg::op_flush_line;
  assign cached       = store || request.op == store_buffer_pkg::op_load;
  assign hit          = cached && read_line.valid && read_line.tag == tag;
  assign victim_dirty = read_line.valid && read_line.dirty;

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      merged[8*b +: 8] = request.strb[b] ? request.data[8*b +: 8] : read_line.data[8*b +: 8];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next   = state;
    write_enable = 1'b0;
    write_line   = '0;
    case (state)
      state_lookup: begin
        if (request.valid) begin
          case (request.op)
            store_buffer_pkg::op_load, store_buffer_pkg::op_store: begin
              if (hit) begin
                write_enable = store;  // merge under strobe, mark dirty.
                write_line   = '{valid: 1'b1, dirty: 1'b1, tag: tag, data: merged};
                state_next   = state_finish;
              end else begin
                state_next = victim_dirty ? state_writeback : state_refill;
              end
            end
            store_buffer_pkg::op_uncached_load:  state_next = state_refill;
            store_buffer_pkg::op_uncached_store: state_next = state_writeback;
            default: state_next = victim_dirty ? state_writeback : state_update;
          endcase
        end
      end
      state_writeback: begin
        if (mem_done) begin
          if (flush) begin
            state_next = state_update;
          end else if (cached) begin
            state_next = state_refill;
          end else begin
            state_next = state_finish;
          end
        end
      end
      state_refill: begin
        if (mem_done) begin
          state_next = mem_cmd.refill ? state_update : state_finish;
        end
      end
      state_update: begin
        write_enable = 1'b1;
        if (flush) begin
          state_next = state_finish;  // line cleared.
        end else begin
          write_line = '{valid: 1'b1, dirty: 1'b0, tag: tag, data: data_q};
          state_next = state_lookup;  // retry now hits.
        end
      end
      default: state_next = state_lookup;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= state_lookup;
    end else begin
      state <= state_next;
    end
  end

  // load data, fill data, or zero for stores and fences.
  always_ff @(posedge clock) begin
    if (state == state_lookup) begin
      data_q <= (hit && !store) ? read_line.data : '0;
    end else if (mem_done && !mem_cmd.store) begin
      data_q <= fill_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory command
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    mem_cmd = '0;
    if (state == state_writeback) begin
      mem_cmd.valid = 1'b1;
      mem_cmd.store = 1'b1;
      if (request.op == store_buffer_pkg::op_uncached_store) begin
        mem_cmd.addr  = request.addr;
        mem_cmd.wdata = request.data;
        mem_cmd.wstrb = request.strb;
      end else begin
        mem_cmd.addr  = {read_line.tag, 3'b000};  // victim address.
        mem_cmd.wdata = read_line.data;
        mem_cmd.wstrb = 8'hff;
      end
    end else if (state == state_refill) begin
      mem_cmd.valid  = 1'b1;
      mem_cmd.refill = cached;
      mem_cmd.addr   = cached ? {tag, 3'b000} : request.addr;
    end
  end

  assign done        = state == state_finish;
  assign finish      = done && (!flush || &index);  // only the last fence step answers.
  assign finish_data = data_q;

  write_needs_request: assert property (@(posedge clock) disable iff (!reset)
    write_enable |-> request.valid)
    else $error("line write without a pending request.");

endmodule

// File: store_buffer_result.sv
module store_buffer_result (
  input  logic                       clock,
  input  logic                       reset,
  input  store_buffer_pkg::mem_cmd_t mem_cmd,
  output logic                       mem_done,
  output logic [63:0]                fill_data,
  input  logic                       finish,
  input  logic [63:0]                finish_data,
  output store_buffer_pkg::mem_req_t mem_req,
  input  store_buffer_pkg::mem_rsp_t mem_rsp,
  output store_buffer_pkg::cpu_rsp_t cpu_rsp
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // command is held by execute until mem_done.
  always_comb begin
    mem_req.valid = mem_cmd.valid;
    mem_req.store = mem_cmd.store;
    mem_req.addr  = mem_cmd.addr;
    mem_req.wdata = mem_cmd.store ? mem_cmd.wdata : '0;
    mem_req.wstrb = mem_cmd.store ? mem_cmd.wstrb : '0;
  end

  assign mem_done  = mem_cmd.valid && mem_rsp.ready;  // transfer cycle.
  assign fill_data = mem_rsp.rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      cpu_rsp.ready <= 1'b0;
    end else begin
      cpu_rsp.ready <= finish;
    end
  end

  always_ff @(posedge clock) begin
    cpu_rsp.rdata <= finish ? finish_data : '0;  // zero outside a response.
  end

  mem_req_stable: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid && !mem_rsp.ready |=> $stable(mem_req))
    else $error("mem_req changed before ready.");

endmodule

// File: store_buffer.sv
module store_buffer #(
  parameter int line_count = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  store_buffer_pkg::cpu_req_t cpu_req,
  output store_buffer_pkg::cpu_rsp_t cpu_rsp,
  output store_buffer_pkg::mem_req_t mem_req,
  input  store_buffer_pkg::mem_rsp_t mem_rsp
);

  localparam int index_width = $clog2(line_count);

  store_buffer_pkg::decoded_t request;
  store_buffer_pkg::line_t    read_line;
  store_buffer_pkg::line_t    write_line;
  store_buffer_pkg::mem_cmd_t mem_cmd;
  logic [index_width-1:0]     read_index;
  logic [index_width-1:0]     write_index;
  logic                       write_enable;
  logic                       done;
  logic                       mem_done;
  logic                       finish;
  logic [63:0]                fill_data;
  logic [63:0]                finish_data;

  store_buffer_decode #(
    .line_count(line_count)
  ) decode (
    .clock  (clock),
    .reset  (reset),
    .cpu_req(cpu_req),
    .done   (done),
    .request(request)
  );

  store_buffer_execute #(
    .line_count(line_count)
  ) execute (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .done        (done),
    .read_index  (read_index),
    .read_line   (read_line),
    .write_enable(write_enable),
    .write_index (write_index),
    .write_line  (write_line),
    .mem_cmd     (mem_cmd),
    .mem_done    (mem_done),
    .fill_data   (fill_data),
    .finish      (finish),
    .finish_data (finish_data)
  );

  store_buffer_lines #(
    .line_count(line_count)
  ) lines (
    .clock       (clock),
    .reset       (reset),
    .read_index  (read_index),
    .read_line   (read_line),
    .write_enable(write_enable),
    .write_index (write_index),
    .write_line  (write_line)
  );

  store_buffer_result result (
    .clock      (clock),
    .reset      (reset),
    .mem_cmd    (mem_cmd),
    .mem_done   (mem_done),
    .fill_data  (fill_data),
    .finish     (finish),
    .finish_data(finish_data),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .cpu_rsp    (cpu_rsp)
  );

endmodule

// File: store_buffer_mem_model.sv
module store_buffer_mem_model (
  input  logic                       clock,
  input  logic                       reset,
  input  store_buffer_pkg::mem_req_t mem_req,
  output store_buffer_pkg::mem_rsp_t mem_rsp
);

  timeunit 1ns;
  timeprecision 1ns;

  logic [63:0] words [logic [28:0]];
  logic [2:0]  delay;

  // untouched words read back a pattern built from the whole word address.
  function automatic logic [63:0] initial_word(input logic [28:0] word);
    return {word ^ 29'h000bf8d, 6'h2a, word};
  endfunction

  function automatic logic [63:0] read_word(input logic [28:0] word);
    if (words.exists(word)) begin
      return words[word];
    end
    return initial_word(word);
  endfunction

  function automatic logic [63:0] merge_word(input logic [63:0] old_word,
                                             input logic [63:0] new_word,
                                             input logic [7:0]  strobe);
    logic [63:0] result;
    result = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strobe[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  initial begin
    mem_rsp <= '0;
    delay   <= '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ready after a random wait, one transfer per ready
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a held request makes the store final when ready rises.
  always @(negedge clock) begin
    if (!reset) begin
      mem_rsp.ready <= 1'b0;
      mem_rsp.rdata <= '0;
      delay         <= '0;
    end else if (mem_rsp.ready) begin
      mem_rsp.ready <= 1'b0;  // transfer took place on the rising edge.
      delay         <= 3'($urandom_range(0, 4));
    end else if (mem_req.valid) begin
      if (delay == 3'd0) begin
        mem_rsp.ready <= 1'b1;
        mem_rsp.rdata <= read_word(mem_req.addr[31:3]);  // request is held stable.
        if (mem_req.store) begin
          words[mem_req.addr[31:3]] = merge_word(read_word(mem_req.addr[31:3]),
                                                 mem_req.wdata, mem_req.wstrb);
        end
      end else begin
        delay <= delay - 3'd1;
      end
    end
  end

endmodule

// File: store_buffer_tb.sv
module store_buffer_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int line_count   = 16;
  localparam int random_ops   = 200;
  localparam int directed_ops = 80;
  localparam int cycle_budget = (random_ops + directed_ops) * 64;

  logic                       clock;
  logic                       reset;
  store_buffer_pkg::cpu_req_t cpu_req;
  store_buffer_pkg::cpu_rsp_t cpu_rsp;
  store_buffer_pkg::mem_req_t mem_req;
  store_buffer_pkg::mem_rsp_t mem_rsp;

  logic [63:0] ref_words [logic [store_buffer_pkg::tag_width-1:0]];
  logic [63:0] expect_data;
  logic        started;
  logic        quiet;  // no memory traffic allowed.
  int          errors;
  int          responses;

  store_buffer #(
    .line_count(line_count)
  ) dut (
    .clock  (clock),
    .reset  (reset),
    .cpu_req(cpu_req),
    .cpu_rsp(cpu_rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  store_buffer_mem_model memory (
    .clock  (clock),
    .reset  (reset),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference word model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [63:0] model_word(input logic [31:0] addr);
    logic [store_buffer_pkg::tag_width-1:0] word;
    word = addr[31:3];
    if (ref_words.exists(word)) begin
      return ref_words[word];
    end
    return {word ^ 29'h000bf8d, 6'h2a, word};  // same fill as the memory.
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  strobe);
    logic [63:0] result;
    result = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strobe[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  idle_after_reset: assert property (@(posedge clock) disable iff (!reset)
    !started |-> !cpu_rsp.ready && !mem_req.valid)
    else report("activity before the first request");

  response_data: assert property (@(posedge clock) disable iff (!reset)
    cpu_rsp.ready |-> cpu_rsp.rdata == expect_data)
    else report("response data differs from the model");

  no_memory_traffic: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> !quiet)
    else report("memory request where none was expected");

  uncached_store_fields: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid && mem_req.store && mem_req.addr[31:28] == 4'h0 |->
      mem_req.addr == cpu_req.addr && mem_req.wdata == cpu_req.wdata &&
      mem_req.wstrb == cpu_req.wstrb)
    else report("uncached store fields differ from the core request");

  writeback_data: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid && mem_req.store && mem_req.addr[31:28] != 4'h0 |->
      mem_req.wstrb == 8'hff && mem_req.wdata == model_word(mem_req.addr))
    else report("writeback word differs from the model");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core side stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // called on a falling edge, returns on a falling edge.
  task automatic access(input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] wstrb, input logic fence);
    expect_data = (fence || (|wstrb)) ? 64'h0 : model_word(addr);
    started     = 1'b1;
    cpu_req     = '{valid: 1'b1, fence: fence, addr: addr, wdata: wdata, wstrb: wstrb};
    do begin
      @(negedge clock);
    end while (!cpu_rsp.ready);
    responses++;
    @(negedge clock);  // request completed on the rising edge just passed.
    if (!fence && (|wstrb)) begin
      ref_words[addr[31:3]] = merge_bytes(model_word(addr), wdata, wstrb);
    end
    cpu_req = '0;
  endtask

  task automatic load_word(input logic [31:0] addr);
    access(addr, 64'h0, 8'h00, 1'b0);
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    access(addr, data, strb, 1'b0);
  endtask

  task automatic run_fence();
    access(32'h0, 64'h0, 8'h00, 1'b1);
  endtask

  initial begin
    int          sel;
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
    void'($urandom(32'hbf8d));
    cpu_req     = '0;
    reset       = 1'b0;
    started     = 1'b0;
    quiet       = 1'b0;
    errors      = 0;
    responses   = 0;
    expect_data = '0;
    repeat (10) @(negedge clock);
    reset = 1'b1;
    repeat (4) @(negedge clock);  // idle window after reset.

    // store then load hit, no memory traffic on the load.
    store_word(32'h1000_0040, 64'h1122_3344_5566_7788, 8'h0f);
    quiet = 1'b1;
    load_word(32'h1000_0040);
    quiet = 1'b0;

    // same index, other tag: dirty victims go back to memory.
    store_word(32'h1000_0048, 64'ha5a5_0000_ffff_1234, 8'hf0);
    store_word(32'h2000_0048, 64'h0123_4567_89ab_cdef, 8'hff);
    load_word(32'h1000_0048);

    // uncached path.
    store_word(32'h0000_0100, 64'hcafe_f00d_dead_beef, 8'h3c);
    load_word(32'h0000_0100);
    load_word(32'h0000_0108);

    // fence, then refill every written word from memory.
    store_word(32'h3000_0010, 64'h0f0f_0f0f_0f0f_0f0f, 8'h81);
    store_word(32'h3000_0078, 64'h7777_6666_5555_4444, 8'hff);
    run_fence();
    quiet = 1'b1;
    run_fence();  // nothing left to write back.
    quiet = 1'b0;
    foreach (ref_words[k]) begin
      if (k[28:25] != 4'h0) begin
        load_word({k, 3'b000});
      end
    end
    quiet = 1'b1;
    run_fence();  // clean lines only.
    quiet = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random mix over a few indices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (int n = 0; n < random_ops; n++) begin
      sel  = int'($urandom_range(0, 99));
      data = {$urandom, $urandom};
      strb = 8'($urandom_range(1, 255));
      addr = 32'h1000_0000 + 32'($urandom_range(0, 2) << 28) + 32'($urandom_range(0, 3) << 3);
      if (sel < 5) begin
        run_fence();
      end else if (sel < 20) begin
        addr = 32'h0000_0200 + 32'($urandom_range(0, 3) << 3);
        if (sel < 12) begin
          load_word(addr);
        end else begin
          store_word(addr, data, strb);
        end
      end else if (sel < 60) begin
        store_word(addr, data, strb);
      end else begin
        load_word(addr);
      end
    end

    repeat (2) @(negedge clock);
    $display("errors: %0d, responses: %0d", errors, responses);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    repeat (cycle_budget) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles, errors: %0d",
             cycle_budget, errors);
    $display("test failed");
    $finish;
  end

endmodule

// File: store_buffer.f
store_buffer_pkg.sv
store_buffer_lines.sv
store_buffer_decode.sv
store_buffer_execute.sv
store_buffer_result.sv
store_buffer.sv
store_buffer_mem_model.sv
store_buffer_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the store buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f store_buffer.f \
  --top-module store_buffer_tb -o store_buffer_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/store_buffer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1
